// File: rbk_cfg_pkg.sv
package rbk_cfg_pkg;

  // ============================================================
  // register port
  // ============================================================
  localparam int REG_ADDR_W = 4;                 // word address
  localparam int REG_DATA_W = 32;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_DATA_W-1:0] reg_data_t;

  localparam reg_addr_t REG_OP_EN      = 4'd0;   // bit0 start, reads busy
  localparam reg_addr_t REG_STATUS     = 4'd1;   // bit0 done, write one clears
  localparam reg_addr_t REG_SRC_ADDR   = 4'd2;   // byte address
  localparam reg_addr_t REG_DST_ADDR   = 4'd3;
  localparam reg_addr_t REG_SRC_STRIDE = 4'd4;   // bytes per line step
  localparam reg_addr_t REG_DST_STRIDE = 4'd5;
  localparam reg_addr_t REG_WIDTH      = 4'd6;   // atoms per line
  localparam reg_addr_t REG_HEIGHT     = 4'd7;   // lines

  // ============================================================
  // surface geometry
  // ============================================================
  localparam int DIM_W      = 13;                // both count from one
  localparam int ATOM_CNT_W = 2 * DIM_W;         // width times height

  typedef logic [DIM_W-1:0]      dim_t;
  typedef logic [ATOM_CNT_W-1:0] atom_cnt_t;

  typedef enum logic {
    REG_READ  = 1'b0,
    REG_WRITE = 1'b1
  } reg_kind_e;

  typedef struct packed {
    reg_kind_e kind;
    reg_addr_t addr;
    reg_data_t wdat;
  } csb_req_t;                                   // 37 bits

  typedef struct packed {
    reg_data_t rdat;                             // zero on writes
    logic      wr_ack;
  } csb_resp_t;                                  // 33 bits

  typedef struct packed {
    reg_data_t src_base;
    reg_data_t dst_base;
    reg_data_t src_stride;
    reg_data_t dst_stride;
    dim_t      width;
    dim_t      height;
  } surf_cfg_t;                                  // 154 bits

endpackage

// File: rbk_data_fifo.sv
`timescale 1ns/1ps

module rbk_data_fifo (
  input  logic                 nvdla_core_clk,
  input  logic                 rst_n,
  input  logic                 rd_rsp_valid,
  input  rbk_mem_pkg::rd_rsp_t rd_rsp,
  input  logic                 fifo_pop,
  output logic                 rd_rsp_ready,
  output logic                 fifo_valid,
  output rbk_mem_pkg::rd_rsp_t fifo_data
);

  rbk_mem_pkg::rd_rsp_t               mem [rbk_mem_pkg::FIFO_DEPTH];
  logic [rbk_mem_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [rbk_mem_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [rbk_mem_pkg::FIFO_CNT_W-1:0] count;   // occupancy
  logic                               push;

  assign rd_rsp_ready = (count != rbk_mem_pkg::FIFO_DEPTH);  // low when full
  assign push         = rd_rsp_valid && rd_rsp_ready;
  assign fifo_valid   = (count != '0);
  assign fifo_data    = mem[rd_ptr];                         // head, visible next cycle

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;                 // wraps at depth
      end
      if (fifo_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, fifo_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                               // both or neither
      endcase
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (push) begin
      mem[wr_ptr] <= rd_rsp;
    end
  end

  // full fifo, memory keeps the beat until taken
  a_no_push_full: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_valid && $stable(rd_rsp));

  // write side only pops a valid head
  a_no_pop_empty: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    fifo_pop |-> fifo_valid);

endmodule

// File: rbk_mem_pkg.sv
package rbk_mem_pkg;

  // ============================================================
  // memory interface
  // ============================================================
  localparam int ADDR_W     = 32;
  localparam int ATOM_W     = 64;                // data bits per atom
  localparam int ATOM_BYTES = 8;                 // address step between atoms

  localparam int FIFO_DEPTH = 4;                 // power of two, pointers wrap
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [ATOM_W-1:0] atom_t;

  typedef struct packed {
    addr_t addr;
  } rd_req_t;                                    // 32 bits

  typedef struct packed {
    atom_t data;
  } rd_rsp_t;                                    // 64 bits

  typedef struct packed {
    addr_t addr;
    atom_t data;
  } wr_req_t;                                    // 96 bits

endpackage

// File: rbk_rd_seq.sv
`timescale 1ns/1ps

module rbk_rd_seq (
  input  logic                   nvdla_core_clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  rbk_cfg_pkg::surf_cfg_t cfg,
  input  logic                   rd_req_ready,
  output logic                   rd_req_valid,
  output rbk_mem_pkg::rd_req_t   rd_req
);

  typedef enum logic {
    RD_IDLE,
    RD_ISSUE
  } rd_state_e;

  rd_state_e           state;
  rbk_cfg_pkg::dim_t   atom_cnt;   // atom within line
  rbk_cfg_pkg::dim_t   line_cnt;
  rbk_cfg_pkg::dim_t   width;      // copies taken at start
  rbk_cfg_pkg::dim_t   height;
  rbk_mem_pkg::addr_t  stride;
  rbk_mem_pkg::addr_t  line_base;  // first atom of current line
  rbk_mem_pkg::addr_t  addr;
  logic                xfer;
  logic                last_atom;
  logic                last_line;

  assign xfer      = rd_req_valid && rd_req_ready;
  assign last_atom = (atom_cnt == width - 1'b1);
  assign last_line = (line_cnt == height - 1'b1);

  assign rd_req_valid = (state == RD_ISSUE);
  assign rd_req.addr  = addr;

  // ============================================================
  // line/atom walk
  // ============================================================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= RD_IDLE;
      atom_cnt <= '0;
      line_cnt <= '0;
    end else if (start) begin
      state    <= RD_ISSUE;                      // first request next cycle
      atom_cnt <= '0;
      line_cnt <= '0;
    end else if (xfer) begin
      if (!last_atom) begin
        atom_cnt <= atom_cnt + 1'b1;
      end else begin
        atom_cnt <= '0;
        line_cnt <= line_cnt + 1'b1;
        if (last_line) begin
          state <= RD_IDLE;                      // last atom accepted
        end
      end
    end
  end

  // address path, holds while not accepted
  always_ff @(posedge nvdla_core_clk) begin
    if (start) begin
      width     <= cfg.width;
      height    <= cfg.height;
      stride    <= cfg.src_stride;
      line_base <= cfg.src_base;
      addr      <= cfg.src_base;
    end else if (xfer) begin
      if (last_atom) begin
        line_base <= line_base + stride;         // next line
        addr      <= line_base + stride;
      end else begin
        addr <= addr + rbk_mem_pkg::addr_t'(rbk_mem_pkg::ATOM_BYTES);
      end
    end
  end

  // request held stable under back-pressure
  a_rd_req_hold: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req));

endmodule

// File: rbk_regfile.sv
`timescale 1ns/1ps

module rbk_regfile (
  input  logic                   nvdla_core_clk,
  input  logic                   rst_n,
  input  logic                   csb_req_valid,
  input  rbk_cfg_pkg::csb_req_t  csb_req,
  input  logic                   done,
  output logic                   csb_resp_valid,
  output rbk_cfg_pkg::csb_resp_t csb_resp,
  output rbk_cfg_pkg::surf_cfg_t cfg,
  output logic                   start,
  output logic                   intr
);

  logic                   op_en;        // busy flag
  logic                   done_status;  // sticky until write one
  logic                   wr_en;
  logic                   rd_en;
  logic                   go;           // accepted start request
  logic                   clr;          // status write-one-clear
  rbk_cfg_pkg::reg_data_t rd_data;

  assign wr_en = csb_req_valid && (csb_req.kind == rbk_cfg_pkg::REG_WRITE);
  assign rd_en = csb_req_valid && (csb_req.kind == rbk_cfg_pkg::REG_READ);
  assign go    = wr_en && (csb_req.addr == rbk_cfg_pkg::REG_OP_EN) && csb_req.wdat[0]
                 && !op_en;  // ignored while busy
  assign clr   = wr_en && (csb_req.addr == rbk_cfg_pkg::REG_STATUS) && csb_req.wdat[0];

  // ============================================================
  // configuration registers
  // ============================================================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (wr_en) begin
      case (csb_req.addr)
        rbk_cfg_pkg::REG_SRC_ADDR:   cfg.src_base   <= csb_req.wdat;
        rbk_cfg_pkg::REG_DST_ADDR:   cfg.dst_base   <= csb_req.wdat;
        rbk_cfg_pkg::REG_SRC_STRIDE: cfg.src_stride <= csb_req.wdat;
        rbk_cfg_pkg::REG_DST_STRIDE: cfg.dst_stride <= csb_req.wdat;
        rbk_cfg_pkg::REG_WIDTH:      cfg.width  <= csb_req.wdat[rbk_cfg_pkg::DIM_W-1:0];
        rbk_cfg_pkg::REG_HEIGHT:     cfg.height <= csb_req.wdat[rbk_cfg_pkg::DIM_W-1:0];
        default: ;                                   // enable/status handled below
      endcase
    end
  end

  // enable, start pulse and done status
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      op_en       <= 1'b0;
      start       <= 1'b0;
      done_status <= 1'b0;
    end else begin
      start <= go;                                   // one cycle, enable rising edge
      if (go) begin
        op_en <= 1'b1;
      end else if (done) begin
        op_en <= 1'b0;                               // hw clears on completion
      end
      if (done) begin
        done_status <= 1'b1;                         // set wins over clear
      end else if (clr) begin
        done_status <= 1'b0;
      end
    end
  end

  assign intr = done_status;                         // level, one register set

  // ============================================================
  // read mux and response
  // ============================================================
  always_comb begin
    rd_data = '0;                                    // unmapped reads zero
    case (csb_req.addr)
      rbk_cfg_pkg::REG_OP_EN:      rd_data[0] = op_en;
      rbk_cfg_pkg::REG_STATUS:     rd_data[0] = done_status;
      rbk_cfg_pkg::REG_SRC_ADDR:   rd_data = cfg.src_base;
      rbk_cfg_pkg::REG_DST_ADDR:   rd_data = cfg.dst_base;
      rbk_cfg_pkg::REG_SRC_STRIDE: rd_data = cfg.src_stride;
      rbk_cfg_pkg::REG_DST_STRIDE: rd_data = cfg.dst_stride;
      rbk_cfg_pkg::REG_WIDTH:      rd_data[rbk_cfg_pkg::DIM_W-1:0] = cfg.width;
      rbk_cfg_pkg::REG_HEIGHT:     rd_data[rbk_cfg_pkg::DIM_W-1:0] = cfg.height;
      default: ;
    endcase
  end

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      csb_resp_valid <= 1'b0;
    end else begin
      csb_resp_valid <= csb_req_valid;               // every request answered next cycle
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    csb_resp.rdat   <= rd_en ? rd_data : '0;
    csb_resp.wr_ack <= wr_en;
  end

  // completion from the write side never lands on a start cycle
  a_start_done_excl: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    !(start && done));

endmodule

// File: rbk_top.sv
`timescale 1ns/1ps

module rbk_top (
  input  logic                   nvdla_core_clk,
  input  logic                   rst_n,
  input  logic                   csb_req_valid,
  input  rbk_cfg_pkg::csb_req_t  csb_req,
  output logic                   csb_resp_valid,
  output rbk_cfg_pkg::csb_resp_t csb_resp,
  output logic                   rd_req_valid,
  input  logic                   rd_req_ready,
  output rbk_mem_pkg::rd_req_t   rd_req,
  input  logic                   rd_rsp_valid,
  output logic                   rd_rsp_ready,
  input  rbk_mem_pkg::rd_rsp_t   rd_rsp,
  output logic                   wr_req_valid,
  input  logic                   wr_req_ready,
  output rbk_mem_pkg::wr_req_t   wr_req,
  input  logic                   wr_rsp_complete,
  output logic                   intr
);

  rbk_cfg_pkg::surf_cfg_t cfg;         // held config
  logic                   start;       // op enable rising edge
  logic                   done;        // last completion
  logic                   fifo_valid;
  logic                   fifo_pop;
  rbk_mem_pkg::rd_rsp_t   fifo_data;

  rbk_regfile u_regfile (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .csb_req_valid  (csb_req_valid),
    .csb_req        (csb_req),
    .done           (done),
    .csb_resp_valid (csb_resp_valid),
    .csb_resp       (csb_resp),
    .cfg            (cfg),
    .start          (start),
    .intr           (intr)
  );

  rbk_rd_seq u_rd_seq (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .start          (start),
    .cfg            (cfg),
    .rd_req_ready   (rd_req_ready),
    .rd_req_valid   (rd_req_valid),
    .rd_req         (rd_req)
  );

  rbk_data_fifo u_data_fifo (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .rd_rsp_valid   (rd_rsp_valid),
    .rd_rsp         (rd_rsp),
    .fifo_pop       (fifo_pop),
    .rd_rsp_ready   (rd_rsp_ready),
    .fifo_valid     (fifo_valid),
    .fifo_data      (fifo_data)
  );

  rbk_wr_req u_wr_req (
    .nvdla_core_clk  (nvdla_core_clk),
    .rst_n           (rst_n),
    .start           (start),
    .cfg             (cfg),
    .fifo_valid      (fifo_valid),
    .fifo_data       (fifo_data),
    .wr_req_ready    (wr_req_ready),
    .wr_rsp_complete (wr_rsp_complete),
    .fifo_pop        (fifo_pop),
    .wr_req_valid    (wr_req_valid),
    .wr_req          (wr_req),
    .done            (done)
  );

endmodule

// File: rbk_wr_req.sv
`timescale 1ns/1ps

module rbk_wr_req (
  input  logic                   nvdla_core_clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  rbk_cfg_pkg::surf_cfg_t cfg,
  input  logic                   fifo_valid,
  input  rbk_mem_pkg::rd_rsp_t   fifo_data,
  input  logic                   wr_req_ready,
  input  logic                   wr_rsp_complete,
  output logic                   fifo_pop,
  output logic                   wr_req_valid,
  output rbk_mem_pkg::wr_req_t   wr_req,
  output logic                   done
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WRITE,
    WR_DRAIN                                     // all issued, waiting completions
  } wr_state_e;

  wr_state_e               state;
  rbk_cfg_pkg::dim_t       atom_cnt;
  rbk_cfg_pkg::dim_t       line_cnt;
  rbk_cfg_pkg::dim_t       width;
  rbk_cfg_pkg::dim_t       height;
  rbk_cfg_pkg::atom_cnt_t  total;        // width times height
  rbk_cfg_pkg::atom_cnt_t  cmpl_cnt;     // completions so far
  rbk_mem_pkg::addr_t      stride;
  rbk_mem_pkg::addr_t      line_base;
  rbk_mem_pkg::addr_t      addr;
  logic                    xfer;
  logic                    last_atom;
  logic                    last_line;

  assign wr_req_valid = (state == WR_WRITE) && fifo_valid;  // head passes straight through
  assign wr_req.addr  = addr;
  assign wr_req.data  = fifo_data.data;
  assign xfer         = wr_req_valid && wr_req_ready;
  assign fifo_pop     = xfer;                               // pop only on accept
  assign last_atom    = (atom_cnt == width - 1'b1);
  assign last_line    = (line_cnt == height - 1'b1);
  assign done         = (state != WR_IDLE) && wr_rsp_complete
                        && (cmpl_cnt == total - 1'b1);

  // ============================================================
  // destination walk and completion count
  // ============================================================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= WR_IDLE;
      atom_cnt <= '0;
      line_cnt <= '0;
      cmpl_cnt <= '0;
    end else if (start) begin
      state    <= WR_WRITE;
      atom_cnt <= '0;
      line_cnt <= '0;
      cmpl_cnt <= '0;
    end else begin
      if (xfer) begin
        if (!last_atom) begin
          atom_cnt <= atom_cnt + 1'b1;
        end else begin
          atom_cnt <= '0;
          line_cnt <= line_cnt + 1'b1;
          if (last_line) begin
            state <= WR_DRAIN;
          end
        end
      end
      if (done) begin
        state <= WR_IDLE;
      end else if (wr_rsp_complete && state != WR_IDLE) begin
        cmpl_cnt <= cmpl_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (start) begin
      width     <= cfg.width;
      height    <= cfg.height;
      total     <= rbk_cfg_pkg::atom_cnt_t'(cfg.width) * rbk_cfg_pkg::atom_cnt_t'(cfg.height);
      stride    <= cfg.dst_stride;
      line_base <= cfg.dst_base;
      addr      <= cfg.dst_base;
    end else if (xfer) begin
      if (last_atom) begin
        line_base <= line_base + stride;
        addr      <= line_base + stride;
      end else begin
        addr <= addr + rbk_mem_pkg::addr_t'(rbk_mem_pkg::ATOM_BYTES);
      end
    end
  end

  // memory only completes writes of a running operation
  a_no_cmpl_idle: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    wr_rsp_complete |-> state != WR_IDLE);

endmodule

// File: sources.f
rbk_cfg_pkg.sv
rbk_mem_pkg.sv
rbk_regfile.sv
rbk_rd_seq.sv
rbk_data_fifo.sv
rbk_wr_req.sv
rbk_top.sv
tb_rbk_mem.sv
tb_rbk.sv

// File: tb_rbk.sv
`timescale 1ns/1ps

module tb_rbk;

  localparam logic [63:0] DATA_KEY = 64'h5a5a_c3c3_0f0f_9696;
  localparam rbk_cfg_pkg::surf_cfg_t SHAPE_A = '{src_base: 32'h0000_1000,
    dst_base: 32'h0000_8000, src_stride: 32'h40, dst_stride: 32'h60,
    width: 13'd5, height: 13'd3};                        // 40 byte lines
  localparam rbk_cfg_pkg::surf_cfg_t SHAPE_B = '{src_base: 32'h0000_2100,
    dst_base: 32'h0000_9000, src_stride: 32'h30, dst_stride: 32'h28,
    width: 13'd3, height: 13'd4};                        // 24 byte lines
  localparam int WATCHDOG_CYCLES = (5 * 3 + 3 * 4) * 40 + 2000;

  logic                   nvdla_core_clk;
  logic                   rst_n;
  logic                   csb_req_valid;
  rbk_cfg_pkg::csb_req_t  csb_req;
  logic                   csb_resp_valid;
  rbk_cfg_pkg::csb_resp_t csb_resp;
  logic                   rd_req_valid;
  logic                   rd_req_ready;
  rbk_mem_pkg::rd_req_t   rd_req;
  logic                   rd_rsp_valid;
  logic                   rd_rsp_ready;
  rbk_mem_pkg::rd_rsp_t   rd_rsp;
  logic                   wr_req_valid;
  logic                   wr_req_ready;
  rbk_mem_pkg::wr_req_t   wr_req;
  logic                   wr_rsp_complete;
  logic                   intr;

  rbk_cfg_pkg::surf_cfg_t shape;      // shape of the running copy
  rbk_cfg_pkg::reg_data_t exp_rdat;   // expected data of the pending read
  logic                   new_op;     // clears the reference walk
  rbk_mem_pkg::addr_t     exp_src;
  rbk_mem_pkg::addr_t     exp_dst;
  rbk_mem_pkg::atom_t     exp_data;
  int                     wr_atom;
  int                     wr_line;
  int                     wr_cnt;
  int                     cmpl_cnt;
  int                     total;
  int                     err_cnt;
  int                     test_cnt;
  int                     fail_cnt;

  rbk_top dut (.*);

  tb_rbk_mem #(.DATA_KEY(DATA_KEY)) u_mem (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #5 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ============================================================
  // reference walk over both surfaces
  // ============================================================
  always_comb begin
    exp_src  = shape.src_base + rbk_mem_pkg::addr_t'(wr_line) * shape.src_stride
               + rbk_mem_pkg::addr_t'(wr_atom * rbk_mem_pkg::ATOM_BYTES);
    exp_dst  = shape.dst_base + rbk_mem_pkg::addr_t'(wr_line) * shape.dst_stride
               + rbk_mem_pkg::addr_t'(wr_atom * rbk_mem_pkg::ATOM_BYTES);
    exp_data = {exp_src, exp_src} ^ DATA_KEY;            // what the model returned
    total    = int'(shape.width) * int'(shape.height);
  end

  always @(posedge nvdla_core_clk) begin
    if (new_op) begin
      wr_atom  <= 0;
      wr_line  <= 0;
      wr_cnt   <= 0;
      cmpl_cnt <= 0;
    end else begin
      if (wr_req_valid && wr_req_ready) begin
        wr_cnt <= wr_cnt + 1;
        if (wr_atom == int'(shape.width) - 1) begin
          wr_atom <= 0;
          wr_line <= wr_line + 1;
        end else begin
          wr_atom <= wr_atom + 1;
        end
      end
      if (wr_rsp_complete) cmpl_cnt <= cmpl_cnt + 1;
    end
  end

  task automatic report_error(input string msg);
    $display("Error: %0t %s", $time, msg);
    err_cnt++;
  endtask

  // ============================================================
  // checks
  // ============================================================
  a_rd_resp: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    csb_req_valid && csb_req.kind == rbk_cfg_pkg::REG_READ
    |=> csb_resp_valid && csb_resp.rdat == $past(exp_rdat))
    else report_error("register read data or response timing wrong");
  a_wr_ack: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    csb_req_valid && csb_req.kind == rbk_cfg_pkg::REG_WRITE |=> csb_resp_valid && csb_resp.wr_ack)
    else report_error("register write not acknowledged");
  a_wr_addr: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    wr_req_valid |-> wr_req.addr == exp_dst)
    else report_error("write address off the destination walk");
  a_wr_data: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    wr_req_valid |-> wr_req.data == exp_data)
    else report_error("write data does not match source atom");
  a_wr_excess: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    wr_req_valid && wr_req_ready |-> wr_cnt < total)
    else report_error("more writes than width times height");
  a_intr_late: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    $rose(intr) |-> cmpl_cnt == total && wr_cnt == total)
    else report_error("interrupt before all writes completed");
  a_intr_clear: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    csb_req_valid && csb_req.kind == rbk_cfg_pkg::REG_WRITE
    && csb_req.addr == rbk_cfg_pkg::REG_STATUS && csb_req.wdat[0] |=> !intr)
    else report_error("interrupt still high after status clear");
  a_rd_hold: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req))
    else report_error("read request changed while stalled");
  a_wr_hold: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req))
    else report_error("write request changed while stalled");

  // one register request, answered by the dut a cycle later
  task automatic reg_access(input rbk_cfg_pkg::reg_kind_e kind, input rbk_cfg_pkg::reg_addr_t addr,
                            input rbk_cfg_pkg::reg_data_t data, input rbk_cfg_pkg::reg_data_t exp);
    @(posedge nvdla_core_clk);
    #1;
    csb_req_valid = 1'b1;
    csb_req.kind  = kind;
    csb_req.addr  = addr;
    csb_req.wdat  = data;
    exp_rdat      = exp;
    @(posedge nvdla_core_clk);
    #1;
    csb_req_valid = 1'b0;
  endtask

  task automatic load_shape(input rbk_cfg_pkg::surf_cfg_t s);
    @(posedge nvdla_core_clk);
    #1;
    shape  = s;
    new_op = 1'b1;                                       // restart reference walk
    @(posedge nvdla_core_clk);
    #1;
    new_op = 1'b0;
    reg_access(rbk_cfg_pkg::REG_WRITE, rbk_cfg_pkg::REG_SRC_ADDR, s.src_base, '0);
    reg_access(rbk_cfg_pkg::REG_WRITE, rbk_cfg_pkg::REG_DST_ADDR, s.dst_base, '0);
    reg_access(rbk_cfg_pkg::REG_WRITE, rbk_cfg_pkg::REG_SRC_STRIDE, s.src_stride, '0);
    reg_access(rbk_cfg_pkg::REG_WRITE, rbk_cfg_pkg::REG_DST_STRIDE, s.dst_stride, '0);
    reg_access(rbk_cfg_pkg::REG_WRITE, rbk_cfg_pkg::REG_WIDTH, 32'(s.width), '0);
    reg_access(rbk_cfg_pkg::REG_WRITE, rbk_cfg_pkg::REG_HEIGHT, 32'(s.height), '0);
  endtask

  task automatic run_copy();
    reg_access(rbk_cfg_pkg::REG_WRITE, rbk_cfg_pkg::REG_OP_EN, 32'd1, '0);
    do @(negedge nvdla_core_clk); while (!intr);        // watchdog bounds this wait
    assert (wr_cnt == total && cmpl_cnt == total)
      else report_error("write or completion count differs from width times height");
    reg_access(rbk_cfg_pkg::REG_READ, rbk_cfg_pkg::REG_STATUS, '0, 32'd1);
    reg_access(rbk_cfg_pkg::REG_READ, rbk_cfg_pkg::REG_OP_EN, '0, 32'd0);
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  // ============================================================
  // sequence
  // ============================================================
  initial begin
    int mark;
    rst_n         = 1'b0;
    csb_req_valid = 1'b0;
    csb_req       = '0;
    exp_rdat      = '0;
    new_op        = 1'b0;
    shape         = '0;
    repeat (16) @(posedge nvdla_core_clk);
    #1;
    rst_n = 1'b1;

    mark = err_cnt;
    load_shape(SHAPE_A);
    reg_access(rbk_cfg_pkg::REG_READ, rbk_cfg_pkg::REG_SRC_ADDR, '0, SHAPE_A.src_base);
    reg_access(rbk_cfg_pkg::REG_READ, rbk_cfg_pkg::REG_DST_ADDR, '0, SHAPE_A.dst_base);
    reg_access(rbk_cfg_pkg::REG_READ, rbk_cfg_pkg::REG_SRC_STRIDE, '0, SHAPE_A.src_stride);
    reg_access(rbk_cfg_pkg::REG_READ, rbk_cfg_pkg::REG_DST_STRIDE, '0, SHAPE_A.dst_stride);
    reg_access(rbk_cfg_pkg::REG_READ, rbk_cfg_pkg::REG_WIDTH, '0, 32'(SHAPE_A.width));
    reg_access(rbk_cfg_pkg::REG_READ, rbk_cfg_pkg::REG_HEIGHT, '0, 32'(SHAPE_A.height));
    reg_access(rbk_cfg_pkg::REG_READ, rbk_cfg_pkg::REG_STATUS, '0, 32'd0);
    reg_access(rbk_cfg_pkg::REG_READ, 4'd8, '0, 32'd0);              // unmapped
    reg_access(rbk_cfg_pkg::REG_READ, 4'd15, '0, 32'd0);
    end_test("register readback", mark);

    mark = err_cnt;
    run_copy();
    end_test("copy shape a", mark);

    mark = err_cnt;
    reg_access(rbk_cfg_pkg::REG_WRITE, rbk_cfg_pkg::REG_STATUS, 32'd1, '0);
    reg_access(rbk_cfg_pkg::REG_READ, rbk_cfg_pkg::REG_STATUS, '0, 32'd0);
    load_shape(SHAPE_B);
    run_copy();
    reg_access(rbk_cfg_pkg::REG_WRITE, rbk_cfg_pkg::REG_STATUS, 32'd1, '0);
    end_test("clear and copy shape b", mark);

    repeat (4) @(posedge nvdla_core_clk);
    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge nvdla_core_clk);
    $display("timeout: copy did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: tb_rbk_mem.sv
`timescale 1ns/1ps

module tb_rbk_mem #(
  parameter logic [63:0] DATA_KEY = 64'h0
) (
  input  logic                 nvdla_core_clk,
  input  logic                 rst_n,
  input  logic                 rd_req_valid,
  output logic                 rd_req_ready,
  input  rbk_mem_pkg::rd_req_t rd_req,
  output logic                 rd_rsp_valid,
  input  logic                 rd_rsp_ready,
  output rbk_mem_pkg::rd_rsp_t rd_rsp,
  input  logic                 wr_req_valid,
  output logic                 wr_req_ready,
  input  rbk_mem_pkg::wr_req_t wr_req,
  output logic                 wr_rsp_complete
);

  rbk_mem_pkg::addr_t rd_q[$];    // accepted reads, oldest first
  int unsigned        due_q[$];   // completion cycles, strictly increasing

  initial begin
    int unsigned        cyc;
    int unsigned        last_due;
    int unsigned        due;
    logic               rd_take;
    logic               rsp_take;
    logic               wr_take;
    rbk_mem_pkg::addr_t rd_addr;
    void'($urandom(72046));                                // stall and delay pattern
    cyc             = 0;
    last_due        = 0;
    rd_req_ready    = 1'b0;
    rd_rsp_valid    = 1'b0;
    rd_rsp          = '0;
    wr_req_ready    = 1'b0;
    wr_rsp_complete = 1'b0;
    forever begin
      @(negedge nvdla_core_clk);                           // handshakes settled mid-cycle
      rd_take  = rst_n && rd_req_valid && rd_req_ready;
      rsp_take = rst_n && rd_rsp_valid && rd_rsp_ready;
      wr_take  = rst_n && wr_req_valid && wr_req_ready;
      rd_addr  = rd_req.addr;
      @(posedge nvdla_core_clk);
      #1;
      cyc++;
      if (rd_take) rd_q.push_back(rd_addr);
      if (rsp_take) begin
        void'(rd_q.pop_front());                           // head beat taken by fifo
        rd_rsp_valid = 1'b0;
      end
      // next beat after a random gap, held until taken
      if (!rd_rsp_valid && rd_q.size() > 0 && ($urandom % 3) != 0) begin
        rd_rsp_valid = 1'b1;
        rd_rsp.data  = {rd_q[0], rd_q[0]} ^ DATA_KEY;
      end
      if (wr_take) begin
        due = cyc + ($urandom % 4);                        // 1 to 4 cycles later
        if (due <= last_due) due = last_due + 1;           // one pulse per cycle
        last_due = due;
        due_q.push_back(due);
      end
      wr_rsp_complete = 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        wr_rsp_complete = 1'b1;
        void'(due_q.pop_front());
      end
      rd_req_ready = ($urandom % 4) != 0;                  // random stalls
      wr_req_ready = ($urandom % 4) != 0;
    end
  end

endmodule
